/* rv_decode_defs.svh */
`ifndef RV_DECODE_DEFS_SVH
`define RV_DECODE_DEFS_SVH

// datapath widths
`define XLEN      32
`define REG_IDX_W 5

// major opcodes in instruction bits 6:2
`define OPC_LUI    5'b01101
`define OPC_AUIPC  5'b00101
`define OPC_JAL    5'b11011
`define OPC_JALR   5'b11001
`define OPC_BRANCH 5'b11000
`define OPC_LOAD   5'b00000
`define OPC_STORE  5'b01000
`define OPC_OP_IMM 5'b00100
`define OPC_OP     5'b01100
`define OPC_SYSTEM 5'b11100

// funct7 groups for OP and the immediate shifts
`define FUNCT7_BASE   7'b0000000
`define FUNCT7_ALT    7'b0100000
`define FUNCT7_MULDIV 7'b0000001

// uncompressed instructions only
`define PC_STEP 4

`endif

/* rv_isa_pkg.sv */
`include "rv_decode_defs.svh"

package rv_isa_pkg;

  // data, address or instruction word
  typedef logic [`XLEN-1:0] word_t;

  // architectural register index
  typedef logic [`REG_IDX_W-1:0] reg_idx_t;

  // minor opcode field in bits 14:12
  typedef logic [2:0] funct3_t;

  // immediate layouts of the base ISA
  typedef enum logic [2:0] {
    IMM_NONE,
    IMM_I,
    IMM_S,
    IMM_B,
    IMM_U,
    IMM_J
  } imm_fmt_t;

endpackage

/* decode_pkg.sv */
package decode_pkg;

  // operation handed to execute
  typedef enum logic [4:0] {
    OP_NONE,
    OP_ADD, OP_SUB, OP_XOR, OP_OR, OP_AND,
    OP_SLL, OP_SLT, OP_SLTU, OP_SRL, OP_SRA,
    OP_MUL, OP_MULH, OP_MULHSU, OP_MULHU,
    OP_DIV, OP_DIVU, OP_REM, OP_REMU,
    OP_LUI,
    OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU,
    OP_SB, OP_SH, OP_SW,
    OP_ECALL, OP_EBREAK
  } exec_op_t;

  // operand a source
  typedef enum logic [1:0] {
    OPA_ZERO,
    OPA_RS1,
    OPA_PC
  } opa_sel_t;

  // operand b source
  typedef enum logic [2:0] {
    OPB_ZERO,
    OPB_RS2,
    OPB_IMM,
    OPB_SHAMT,
    OPB_STEP
  } opb_sel_t;

  // next pc rule
  typedef enum logic [3:0] {
    PC_SEQ,
    PC_JAL, PC_JALR,
    PC_BEQ, PC_BNE, PC_BLT, PC_BGE, PC_BLTU, PC_BGEU
  } pc_sel_t;

endpackage

/* instr_decoder.sv */
`timescale 1ns/1ps
`include "rv_decode_defs.svh"

module instr_decoder
  import rv_isa_pkg::*;
  import decode_pkg::*;
(
  input  word_t    instr,
  output exec_op_t op,
  output imm_fmt_t imm_fmt,
  output opa_sel_t opa_sel,
  output opb_sel_t opb_sel,
  output pc_sel_t  pc_sel,
  output reg_idx_t rd,
  output reg_idx_t rs1,
  output reg_idx_t rs2,
  output logic     illegal
);

  logic [4:0] opcode;
  funct3_t    funct3;
  logic [6:0] funct7;
  logic       rd_en;

  assign opcode = instr[6:2];
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];

  // source fields go straight to the register file
  assign rs1 = instr[19:15];
  assign rs2 = instr[24:20];
  assign rd  = rd_en ? instr[11:7] : '0;

  always_comb begin
    op      = OP_NONE;
    imm_fmt = IMM_NONE;
    opa_sel = OPA_ZERO;
    opb_sel = OPB_ZERO;
    pc_sel  = PC_SEQ;
    rd_en   = 1'b0;
    illegal = 1'b1;
    // compressed quadrants stay illegal
    if (instr[1:0] == 2'b11) begin
      case (opcode)
        `OPC_LUI: begin
          op      = OP_LUI;
          imm_fmt = IMM_U;
          opb_sel = OPB_IMM;
          rd_en   = 1'b1;
          illegal = 1'b0;
        end
        `OPC_AUIPC: begin
          op      = OP_ADD;
          imm_fmt = IMM_U;
          opa_sel = OPA_PC;
          opb_sel = OPB_IMM;
          rd_en   = 1'b1;
          illegal = 1'b0;
        end
        // execute builds the link value pc + 4
        `OPC_JAL: begin
          op      = OP_ADD;
          imm_fmt = IMM_J;
          opa_sel = OPA_PC;
          opb_sel = OPB_STEP;
          pc_sel  = PC_JAL;
          rd_en   = 1'b1;
          illegal = 1'b0;
        end
        `OPC_JALR: begin
          op      = OP_ADD;
          imm_fmt = IMM_I;
          opa_sel = OPA_PC;
          opb_sel = OPB_STEP;
          pc_sel  = PC_JALR;
          rd_en   = 1'b1;
          illegal = (funct3 != 3'b000);
        end
        `OPC_BRANCH: begin
          imm_fmt = IMM_B;
          illegal = 1'b0;
          case (funct3)
            3'b000:  pc_sel = PC_BEQ;
            3'b001:  pc_sel = PC_BNE;
            3'b100:  pc_sel = PC_BLT;
            3'b101:  pc_sel = PC_BGE;
            3'b110:  pc_sel = PC_BLTU;
            3'b111:  pc_sel = PC_BGEU;
            default: illegal = 1'b1;
          endcase
        end
        `OPC_LOAD: begin
          imm_fmt = IMM_I;
          opa_sel = OPA_RS1;
          opb_sel = OPB_IMM;
          rd_en   = 1'b1;
          illegal = 1'b0;
          case (funct3)
            3'b000:  op = OP_LB;
            3'b001:  op = OP_LH;
            3'b010:  op = OP_LW;
            3'b100:  op = OP_LBU;
            3'b101:  op = OP_LHU;
            default: illegal = 1'b1;
          endcase
        end
        // store data rides in operand b
        `OPC_STORE: begin
          imm_fmt = IMM_S;
          opa_sel = OPA_RS1;
          opb_sel = OPB_RS2;
          illegal = 1'b0;
          case (funct3)
            3'b000:  op = OP_SB;
            3'b001:  op = OP_SH;
            3'b010:  op = OP_SW;
            default: illegal = 1'b1;
          endcase
        end
        `OPC_OP_IMM: begin
          imm_fmt = IMM_I;
          opa_sel = OPA_RS1;
          opb_sel = OPB_IMM;
          rd_en   = 1'b1;
          illegal = 1'b0;
          case (funct3)
            3'b000: op = OP_ADD;
            3'b010: op = OP_SLT;
            3'b011: op = OP_SLTU;
            3'b100: op = OP_XOR;
            3'b110: op = OP_OR;
            3'b111: op = OP_AND;
            3'b001: begin
              op      = OP_SLL;
              opb_sel = OPB_SHAMT;
              illegal = (funct7 != `FUNCT7_BASE);
            end
            default: begin
              opb_sel = OPB_SHAMT;
              if (funct7 == `FUNCT7_BASE) begin
                op = OP_SRL;
              end else if (funct7 == `FUNCT7_ALT) begin
                op = OP_SRA;
              end else begin
                illegal = 1'b1;
              end
            end
          endcase
        end
        `OPC_OP: begin
          opa_sel = OPA_RS1;
          opb_sel = OPB_RS2;
          rd_en   = 1'b1;
          illegal = 1'b0;
          case (funct7)
            `FUNCT7_BASE: begin
              case (funct3)
                3'b000:  op = OP_ADD;
                3'b001:  op = OP_SLL;
                3'b010:  op = OP_SLT;
                3'b011:  op = OP_SLTU;
                3'b100:  op = OP_XOR;
                3'b101:  op = OP_SRL;
                3'b110:  op = OP_OR;
                default: op = OP_AND;
              endcase
            end
            `FUNCT7_ALT: begin
              case (funct3)
                3'b000:  op = OP_SUB;
                3'b101:  op = OP_SRA;
                default: illegal = 1'b1;
              endcase
            end
            `FUNCT7_MULDIV: begin
              case (funct3)
                3'b000:  op = OP_MUL;
                3'b001:  op = OP_MULH;
                3'b010:  op = OP_MULHSU;
                3'b011:  op = OP_MULHU;
                3'b100:  op = OP_DIV;
                3'b101:  op = OP_DIVU;
                3'b110:  op = OP_REM;
                default: op = OP_REMU;
              endcase
            end
            default: illegal = 1'b1;
          endcase
        end
        // only ecall and ebreak decode here
        `OPC_SYSTEM: begin
          if (instr[31:7] == {12'h000, 13'h0000}) begin
            op      = OP_ECALL;
            illegal = 1'b0;
          end else if (instr[31:7] == {12'h001, 13'h0000}) begin
            op      = OP_EBREAK;
            illegal = 1'b0;
          end
        end
        default: ;
      endcase
    end
    // partial matches above may have set fields
    if (illegal) begin
      op      = OP_NONE;
      imm_fmt = IMM_NONE;
      opa_sel = OPA_ZERO;
      opb_sel = OPB_ZERO;
      pc_sel  = PC_SEQ;
      rd_en   = 1'b0;
    end
  end

endmodule

/* imm_gen.sv */
`timescale 1ns/1ps

module imm_gen
  import rv_isa_pkg::*;
(
  input  word_t    instr,
  input  imm_fmt_t imm_fmt,
  output word_t    imm
);

  word_t imm_i;
  word_t imm_s;
  word_t imm_b;
  word_t imm_u;
  word_t imm_j;

  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  // b and j keep bit 0 clear
  assign imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'h000};
  assign imm_j = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

  always_comb begin
    case (imm_fmt)
      IMM_I:   imm = imm_i;
      IMM_S:   imm = imm_s;
      IMM_B:   imm = imm_b;
      IMM_U:   imm = imm_u;
      IMM_J:   imm = imm_j;
      default: imm = '0;
    endcase
  end

endmodule

/* next_pc_unit.sv */
`timescale 1ns/1ps
`include "rv_decode_defs.svh"

module next_pc_unit
  import rv_isa_pkg::*;
  import decode_pkg::*;
(
  input  pc_sel_t pc_sel,
  input  word_t   pc,
  input  word_t   rs1_data,
  input  word_t   rs2_data,
  input  word_t   imm,
  output word_t   next_pc
);

  word_t seq_pc;
  word_t rel_pc;
  word_t jalr_pc;
  logic  eq;
  logic  lt_s;
  logic  lt_u;
  logic  taken;

  assign seq_pc  = pc + word_t'(`PC_STEP);
  assign rel_pc  = pc + imm;
  assign jalr_pc = (rs1_data + imm) & ~word_t'(1);

  assign eq   = (rs1_data == rs2_data);
  assign lt_s = ($signed(rs1_data) < $signed(rs2_data));
  assign lt_u = (rs1_data < rs2_data);

  // branch outcome
  always_comb begin
    case (pc_sel)
      PC_BEQ:  taken = eq;
      PC_BNE:  taken = !eq;
      PC_BLT:  taken = lt_s;
      PC_BGE:  taken = !lt_s;
      PC_BLTU: taken = lt_u;
      PC_BGEU: taken = !lt_u;
      default: taken = 1'b0;
    endcase
  end

  always_comb begin
    case (pc_sel)
      PC_JAL:  next_pc = rel_pc;
      PC_JALR: next_pc = jalr_pc;
      PC_BEQ, PC_BNE, PC_BLT, PC_BGE, PC_BLTU, PC_BGEU: begin
        next_pc = taken ? rel_pc : seq_pc;
      end
      default: next_pc = seq_pc;
    endcase
  end

endmodule

/* decode_stage.sv */
`timescale 1ns/1ps
`include "rv_decode_defs.svh"

module decode_stage
  import rv_isa_pkg::*;
  import decode_pkg::*;
(
  input  logic     clk,
  input  logic     reset,
  input  logic     in_valid,
  output logic     in_ready,
  input  word_t    in_instr,
  input  word_t    in_pc,
  output reg_idx_t rs1,
  output reg_idx_t rs2,
  input  word_t    rs1_data,
  input  word_t    rs2_data,
  output logic     out_valid,
  input  logic     out_ready,
  output exec_op_t out_op,
  output reg_idx_t out_rd,
  output word_t    out_operand_a,
  output word_t    out_operand_b,
  output word_t    out_mem_addr,
  output word_t    out_next_pc,
  output logic     out_illegal
);

  exec_op_t dec_op;
  imm_fmt_t imm_fmt;
  opa_sel_t opa_sel;
  opb_sel_t opb_sel;
  pc_sel_t  pc_sel;
  reg_idx_t dec_rd;
  logic     dec_illegal;
  word_t    imm;
  word_t    next_pc;
  word_t    operand_a;
  word_t    operand_b;
  logic     load;

  instr_decoder u_instr_decoder (
    .instr   (in_instr),
    .op      (dec_op),
    .imm_fmt (imm_fmt),
    .opa_sel (opa_sel),
    .opb_sel (opb_sel),
    .pc_sel  (pc_sel),
    .rd      (dec_rd),
    .rs1     (rs1),
    .rs2     (rs2),
    .illegal (dec_illegal)
  );

  imm_gen u_imm_gen (
    .instr   (in_instr),
    .imm_fmt (imm_fmt),
    .imm     (imm)
  );

  next_pc_unit u_next_pc_unit (
    .pc_sel   (pc_sel),
    .pc       (in_pc),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .imm      (imm),
    .next_pc  (next_pc)
  );

  always_comb begin
    case (opa_sel)
      OPA_RS1: operand_a = rs1_data;
      OPA_PC:  operand_a = in_pc;
      default: operand_a = '0;
    endcase
  end

  // shift amount is the zero extended rs2 field
  always_comb begin
    case (opb_sel)
      OPB_RS2:   operand_b = rs2_data;
      OPB_IMM:   operand_b = imm;
      OPB_SHAMT: operand_b = word_t'(rs2);
      OPB_STEP:  operand_b = word_t'(`PC_STEP);
      default:   operand_b = '0;
    endcase
  end

  // register is free when empty or draining this cycle
  assign in_ready = !out_valid || out_ready;
  assign load     = in_valid && in_ready;

  always_ff @(posedge clk) begin
    if (reset) begin
      out_valid     <= 1'b0;
      out_op        <= OP_NONE;
      out_rd        <= '0;
      out_operand_a <= '0;
      out_operand_b <= '0;
      out_mem_addr  <= '0;
      out_next_pc   <= '0;
      out_illegal   <= 1'b0;
    end else begin
      if (in_ready) begin
        out_valid <= in_valid;
      end
      if (load) begin
        out_op        <= dec_op;
        out_rd        <= dec_rd;
        out_operand_a <= operand_a;
        out_operand_b <= operand_b;
        out_mem_addr  <= rs1_data + imm;
        out_next_pc   <= next_pc;
        out_illegal   <= dec_illegal;
      end
    end
  end

endmodule

/* tb_decode_stage.sv */
`timescale 1ns/1ps
`include "rv_decode_defs.svh"

module tb_decode_stage
  import rv_isa_pkg::*;
  import decode_pkg::*;
();

  typedef struct packed {
    exec_op_t op;
    reg_idx_t rd;
    word_t    a;
    word_t    b;
    word_t    addr;
    word_t    npc;
    logic     illegal;
  } expect_t;

  logic     clk = 1'b0;
  logic     reset;
  logic     in_valid;
  logic     in_ready;
  word_t    in_instr;
  word_t    in_pc;
  reg_idx_t rs1;
  reg_idx_t rs2;
  word_t    rs1_data;
  word_t    rs2_data;
  logic     out_valid;
  logic     out_ready = 1'b1;
  exec_op_t out_op;
  reg_idx_t out_rd;
  word_t    out_operand_a;
  word_t    out_operand_b;
  word_t    out_mem_addr;
  word_t    out_next_pc;
  logic     out_illegal;

  expect_t exp_q[$];
  expect_t held;
  logic    stalled = 1'b0;
  logic    was_reset = 1'b1;
  logic    ready_random = 1'b0;
  logic    timed_out = 1'b0;
  int      error_count = 0;
  int      check_count = 0;
  int      accept_count = 0;
  int      transfer_count = 0;

  decode_stage u_decode_stage (.*);

  always #10 clk = ~clk;

  // register file model with x0 reading zero
  function automatic word_t reg_value(reg_idx_t idx);
    return (idx == 5'd0) ? '0 : (word_t'(idx) * 32'h9e3779b1) ^ 32'h0f0f3c3c;
  endfunction

  assign rs1_data = reg_value(rs1);
  assign rs2_data = reg_value(rs2);

  always @(negedge clk) begin
    out_ready <= ready_random ? 1'($urandom % 2) : 1'b1;
  end

  function automatic exec_op_t alu_op(logic [2:0] f3, logic alt);
    case (f3)
      3'd0:    return alt ? OP_SUB : OP_ADD;
      3'd1:    return OP_SLL;
      3'd2:    return OP_SLT;
      3'd3:    return OP_SLTU;
      3'd4:    return OP_XOR;
      3'd5:    return alt ? OP_SRA : OP_SRL;
      3'd6:    return OP_OR;
      default: return OP_AND;
    endcase
  endfunction

  function automatic exec_op_t muldiv_op(logic [2:0] f3);
    case (f3)
      3'd0:    return OP_MUL;
      3'd1:    return OP_MULH;
      3'd2:    return OP_MULHSU;
      3'd3:    return OP_MULHU;
      3'd4:    return OP_DIV;
      3'd5:    return OP_DIVU;
      3'd6:    return OP_REM;
      default: return OP_REMU;
    endcase
  endfunction

  function automatic expect_t ref_decode(word_t instr, word_t pc, word_t r1, word_t r2);
    expect_t    e;
    word_t      imm_i;
    word_t      imm_s;
    word_t      imm_b;
    word_t      imm_u;
    word_t      imm_j;
    word_t      imm;
    logic [2:0] f3;
    logic [6:0] f7;
    logic       ok;
    logic       taken;
    f3 = instr[14:12];
    f7 = instr[31:25];
    // immediates by arithmetic shift of the packed fields
    imm_i = word_t'($signed(instr) >>> 20);
    imm_s = word_t'($signed({instr[31:25], instr[11:7], 20'h0}) >>> 20);
    imm_b = word_t'($signed({instr[31], instr[7], instr[30:25], instr[11:8], 20'h0}) >>> 19);
    imm_u = {instr[31:12], 12'h000};
    imm_j = word_t'($signed({instr[31], instr[19:12], instr[20], instr[30:21], 12'h0}) >>> 11);
    ok = 1'b1;
    taken = 1'b0;
    imm = '0;
    e.op = OP_NONE;
    e.rd = instr[11:7];
    e.a = '0;
    e.b = '0;
    e.npc = pc + 32'd4;
    if (instr[1:0] != 2'b11) begin
      ok = 1'b0;
    end else begin
      case (instr[6:2])
        `OPC_LUI: begin
          e.op = OP_LUI;
          imm = imm_u;
          e.b = imm_u;
        end
        `OPC_AUIPC: begin
          e.op = OP_ADD;
          imm = imm_u;
          e.a = pc;
          e.b = imm_u;
        end
        `OPC_JAL: begin
          e.op = OP_ADD;
          imm = imm_j;
          e.a = pc;
          e.b = 32'd4;
          e.npc = pc + imm_j;
        end
        `OPC_JALR: begin
          ok = (f3 == 3'd0);
          e.op = OP_ADD;
          imm = imm_i;
          e.a = pc;
          e.b = 32'd4;
          e.npc = (r1 + imm_i) & ~32'h1;
        end
        `OPC_BRANCH: begin
          e.rd = '0;
          imm = imm_b;
          case (f3)
            3'd0:    taken = (r1 == r2);
            3'd1:    taken = (r1 != r2);
            3'd4:    taken = ($signed(r1) < $signed(r2));
            3'd5:    taken = ($signed(r1) >= $signed(r2));
            3'd6:    taken = (r1 < r2);
            3'd7:    taken = (r1 >= r2);
            default: ok = 1'b0;
          endcase
          if (taken) begin
            e.npc = pc + imm_b;
          end
        end
        `OPC_LOAD: begin
          imm = imm_i;
          e.a = r1;
          e.b = imm_i;
          case (f3)
            3'd0:    e.op = OP_LB;
            3'd1:    e.op = OP_LH;
            3'd2:    e.op = OP_LW;
            3'd4:    e.op = OP_LBU;
            3'd5:    e.op = OP_LHU;
            default: ok = 1'b0;
          endcase
        end
        `OPC_STORE: begin
          e.rd = '0;
          imm = imm_s;
          e.a = r1;
          e.b = r2;
          case (f3)
            3'd0:    e.op = OP_SB;
            3'd1:    e.op = OP_SH;
            3'd2:    e.op = OP_SW;
            default: ok = 1'b0;
          endcase
        end
        `OPC_OP_IMM: begin
          imm = imm_i;
          e.a = r1;
          e.b = imm_i;
          e.op = alu_op(f3, (f3 == 3'd5) && (f7 == 7'h20));
          if (f3 == 3'd1 || f3 == 3'd5) begin
            e.b = {27'h0, instr[24:20]};
            ok = (f7 == 7'h00) || (f3 == 3'd5 && f7 == 7'h20);
          end
        end
        `OPC_OP: begin
          e.a = r1;
          e.b = r2;
          if (f7 == 7'h01) begin
            e.op = muldiv_op(f3);
          end else if (f7 == 7'h00) begin
            e.op = alu_op(f3, 1'b0);
          end else if (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5)) begin
            e.op = alu_op(f3, 1'b1);
          end else begin
            ok = 1'b0;
          end
        end
        `OPC_SYSTEM: begin
          e.rd = '0;
          if (instr[31:7] == 25'h0) begin
            e.op = OP_ECALL;
          end else if (instr[31:7] == 25'h2000) begin
            e.op = OP_EBREAK;
          end else begin
            ok = 1'b0;
          end
        end
        default: ok = 1'b0;
      endcase
    end
    if (!ok) begin
      e.op = OP_NONE;
      e.rd = '0;
      e.a = '0;
      e.b = '0;
      e.npc = pc + 32'd4;
      imm = '0;
    end
    e.addr = r1 + imm;
    e.illegal = !ok;
    return e;
  endfunction

  task automatic check_op(string what, exec_op_t got, exec_op_t exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("ERROR %0t ns: %s is %s, expected %s", $time, what, got.name(), exp.name());
    end
  endtask

  task automatic check_idx(string what, reg_idx_t got, reg_idx_t exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("ERROR %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic check_word(string what, word_t got, word_t exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("ERROR %0t ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_bit(string what, logic got, logic exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("ERROR %0t ns: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic compare_entry(expect_t e, string tag);
    check_op({tag, " op"}, out_op, e.op);
    check_idx({tag, " rd"}, out_rd, e.rd);
    check_word({tag, " operand a"}, out_operand_a, e.a);
    check_word({tag, " operand b"}, out_operand_b, e.b);
    check_word({tag, " mem addr"}, out_mem_addr, e.addr);
    check_word({tag, " next pc"}, out_next_pc, e.npc);
    check_bit({tag, " illegal"}, out_illegal, e.illegal);
  endtask

  // sampled at the rising edge before the DUT registers update
  always @(posedge clk) begin
    if (reset) begin
      was_reset = 1'b1;
      stalled = 1'b0;
    end else begin
      if (was_reset) begin
        check_bit("out_valid after reset", out_valid, 1'b0);
        check_bit("in_ready after reset", in_ready, 1'b1);
        check_word("next pc after reset", out_next_pc, '0);
      end else begin
        // pending entries are what the stage holds
        check_bit("out_valid", out_valid, exp_q.size() != 0);
        check_bit("in_ready", in_ready, exp_q.size() == 0 || out_ready);
      end
      was_reset = 1'b0;
      if (stalled) begin
        check_bit("out_valid while stalled", out_valid, 1'b1);
        compare_entry(held, "stalled");
      end
      if (out_valid && out_ready) begin
        if (exp_q.size() == 0) begin
          error_count++;
          $display("ERROR %0t ns: output transfer with no instruction pending", $time);
        end else begin
          compare_entry(exp_q.pop_front(), "result");
          transfer_count++;
        end
      end
      if (in_valid && in_ready) begin
        check_idx("rs1 index", rs1, in_instr[19:15]);
        check_idx("rs2 index", rs2, in_instr[24:20]);
        exp_q.push_back(ref_decode(in_instr, in_pc, reg_value(in_instr[19:15]),
                                   reg_value(in_instr[24:20])));
        accept_count++;
      end
      stalled = out_valid && !out_ready;
      held = '{out_op, out_rd, out_operand_a, out_operand_b, out_mem_addr, out_next_pc,
               out_illegal};
    end
  end

  function automatic word_t rand_pc();
    return $urandom & 32'hffff_fffc;
  endfunction

  // kinds below 9 are legal groups and 9 gives illegal encodings
  function automatic word_t make_instr(int kind);
    word_t      w;
    logic [2:0] f3;
    logic [2:0] pick;
    w = $urandom;
    w[1:0] = 2'b11;
    f3 = w[14:12];
    pick = 3'($urandom % 6);
    case (kind)
      0: begin
        w[6:2] = `OPC_OP;
        if (pick < 3'd2) begin
          w[31:25] = `FUNCT7_BASE;
        end else if (pick < 3'd4) begin
          w[31:25] = `FUNCT7_MULDIV;
        end else begin
          w[31:25] = `FUNCT7_ALT;
          f3 = pick[0] ? 3'b101 : 3'b000;
        end
      end
      1: begin
        w[6:2] = `OPC_OP_IMM;
        if (f3 == 3'b001) w[31:25] = `FUNCT7_BASE;
        if (f3 == 3'b101) w[31:25] = pick[0] ? `FUNCT7_ALT : `FUNCT7_BASE;
      end
      2: begin
        w[6:2] = `OPC_LOAD;
        f3 = 3'($urandom % 5);
        if (f3 > 3'd2) f3 = f3 + 3'd1;
      end
      3: begin
        w[6:2] = `OPC_STORE;
        f3 = 3'($urandom % 3);
      end
      4: begin
        w[6:2] = `OPC_BRANCH;
        f3 = (pick < 3'd2) ? pick : pick + 3'd2;
        // equal sources now and then
        if (w[31:30] == 2'b00) w[24:20] = w[19:15];
      end
      5: w[6:2] = `OPC_JAL;
      6: begin
        w[6:2] = `OPC_JALR;
        f3 = 3'b000;
      end
      7: w[6:2] = pick[0] ? `OPC_LUI : `OPC_AUIPC;
      8: begin
        w = pick[0] ? 32'h0010_0073 : 32'h0000_0073;
        f3 = 3'b000;
      end
      default: begin
        case (pick)
          3'd0: w[1:0] = 2'($urandom % 3);
          3'd1: begin
            w[6:2] = `OPC_SYSTEM;
            f3 = 3'($urandom % 7) + 3'd1;
          end
          3'd2: w[6:2] = 5'b00011;
          3'd3: begin
            w[6:2] = `OPC_OP;
            w[31:25] = `FUNCT7_ALT;
            f3 = 3'b001;
          end
          3'd4: begin
            w[6:2] = `OPC_BRANCH;
            f3 = {2'b01, w[7]};
          end
          default: begin
            w[6:2] = `OPC_JALR;
            f3 = f3 | 3'b100;
          end
        endcase
      end
    endcase
    w[14:12] = f3;
    return w;
  endfunction

  task automatic send(word_t instr, word_t pc);
    int   cycles;
    logic accepted;
    @(negedge clk);
    in_valid = 1'b1;
    in_instr = instr;
    in_pc = pc;
    cycles = 0;
    accepted = 1'b0;
    while (!accepted && cycles < 100) begin
      @(posedge clk);
      accepted = in_ready;
      cycles++;
    end
    if (!accepted) begin
      $display("timeout: in_ready stayed low for %0d cycles", cycles);
      timed_out = 1'b1;
    end
  endtask

  task automatic idle_cycle();
    @(negedge clk);
    in_valid = 1'b0;
  endtask

  // negative kind mixes all groups with gaps
  task automatic run_phase(int kind, int count);
    int n;
    for (n = 0; n < count && !timed_out; n++) begin
      if (kind < 0) begin
        if (($urandom % 4) == 0) idle_cycle();
        send(make_instr(int'($urandom % 10)), rand_pc());
      end else begin
        send(make_instr(kind), rand_pc());
      end
    end
  endtask

  initial begin
    int cycles;
    void'($urandom(32'h955a57a9));
    reset = 1'b1;
    in_valid = 1'b0;
    in_instr = '0;
    in_pc = '0;
    repeat (10) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    run_phase(0, 60);
    run_phase(1, 60);
    run_phase(2, 25);
    run_phase(3, 25);
    run_phase(4, 60);
    run_phase(5, 10);
    run_phase(6, 10);
    run_phase(7, 15);
    run_phase(8, 4);
    run_phase(9, 40);
    ready_random = 1'b1;
    run_phase(-1, 300);
    @(negedge clk);
    in_valid = 1'b0;
    cycles = 0;
    while (exp_q.size() != 0 && cycles < 1000) begin
      @(negedge clk);
      cycles++;
    end
    if (exp_q.size() != 0) begin
      $display("timeout: %0d instructions never left the decode stage", exp_q.size());
      timed_out = 1'b1;
    end
    $display("checks: %0d, errors: %0d, accepted: %0d, transferred: %0d",
             check_count, error_count, accept_count, transfer_count);
    if (error_count == 0 && !timed_out && accept_count > 0 &&
        accept_count == transfer_count) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

/* verilog.f */
+incdir+.
rv_isa_pkg.sv
decode_pkg.sv
instr_decoder.sv
imm_gen.sv
next_pc_unit.sv
decode_stage.sv
tb_decode_stage.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       := tb_decode_stage
FILELIST  := verilog.f
OBJ_DIR   := obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "Regression passed"

clean:
	rm -rf $(OBJ_DIR)
